//--- include/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Clock cycles in one serial bit.
`define UART_CLOCKS_PER_BIT 16

// Receiver samples per serial bit.
`define UART_OVERSAMPLE 8

// Payload bits in one frame.
`define UART_DATA_BITS 8

// Entries in each of the two FIFOs.
`define UART_FIFO_DEPTH 16

`endif

//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// Receiver FSM states.
	typedef enum logic [1:0] {
		rx_idle  = 2'd0,
		rx_start = 2'd1,
		rx_data  = 2'd2,
		rx_stop  = 2'd3
	} rx_state_t;

	// Register map of the bus front end.
	typedef enum logic [1:0] {
		reg_rx_data = 2'd0,
		reg_status  = 2'd1,
		reg_tx_data = 2'd2,
		reg_unused  = 2'd3
	} reg_address_t;

endpackage

`default_nettype wire

//--- rtl/uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  wire logic             i_clock,
	input  wire logic             i_reset,
	input  wire logic             i_write,
	input  wire logic [WIDTH-1:0] i_wdata,
	input  wire logic             i_read,
	output logic      [WIDTH-1:0] o_rdata,
	output logic                  o_empty,
	output logic                  o_full
);
	localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] memory [DEPTH];
	logic [ADDR_WIDTH-1:0] read_pointer;
	logic [ADDR_WIDTH-1:0] write_pointer;
	logic [COUNT_WIDTH-1:0] count;
	logic do_write;
	logic do_read;

	assign o_empty = (count == '0);
	assign o_full = (count == COUNT_WIDTH'(DEPTH));

	// Writes when full and reads when empty are dropped.
	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	always_ff @(posedge i_clock) begin
		if (do_write) begin
			memory[write_pointer] <= i_wdata;
		end
		if (do_read) begin
			o_rdata <= memory[read_pointer];
		end
	end

	// Pointers wrap explicitly so any depth works.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			read_pointer <= '0;
			write_pointer <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				write_pointer <= (write_pointer == ADDR_WIDTH'(DEPTH - 1)) ?
					'0 : write_pointer + 1'b1;
			end
			if (do_read) begin
				read_pointer <= (read_pointer == ADDR_WIDTH'(DEPTH - 1)) ?
					'0 : read_pointer + 1'b1;
			end
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_receiver.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uart_receiver (
	input  wire logic                        i_clock,
	input  wire logic                        i_reset,
	input  wire logic                        i_uart_rx,
	output logic                             o_valid,
	output logic [`UART_DATA_BITS-1:0]       o_data,
	output logic                             o_interrupt
);
	import uart_pkg::*;

	localparam int TICK_DIV = `UART_CLOCKS_PER_BIT / `UART_OVERSAMPLE;
	localparam int TICK_WIDTH = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam int SAMPLE_WIDTH = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_WIDTH = $clog2(`UART_DATA_BITS);

	logic [1:0] rx_sync;
	logic [TICK_WIDTH-1:0] tick_count;
	logic sample_tick;
	logic [SAMPLE_WIDTH-1:0] sample_count;
	logic [BIT_WIDTH-1:0] bit_index;
	rx_state_t state;

	// Free running divider for the oversample tick.
	assign sample_tick = (tick_count == TICK_WIDTH'(TICK_DIV - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_sync <= 2'b11;
			tick_count <= '0;
		end else begin
			rx_sync <= {rx_sync[0], i_uart_rx};
			tick_count <= sample_tick ? '0 : tick_count + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= rx_idle;
			sample_count <= '0;
			bit_index <= '0;
			o_valid <= 1'b0;
			o_interrupt <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			o_interrupt <= 1'b0;
			if (sample_tick) begin
				if (state == rx_idle) begin
					// Line went low, wait half a bit.
					if (!rx_sync[1]) begin
						state <= rx_start;
						sample_count <= SAMPLE_WIDTH'(`UART_OVERSAMPLE / 2 - 1);
					end
				end else if (sample_count != '0) begin
					sample_count <= sample_count - 1'b1;
				end else begin
					sample_count <= SAMPLE_WIDTH'(`UART_OVERSAMPLE - 1);
					case (state)
						rx_start: begin
							// High again here means a glitch.
							state <= rx_sync[1] ? rx_idle : rx_data;
							bit_index <= '0;
						end
						rx_data: begin
							o_data <= {rx_sync[1], o_data[`UART_DATA_BITS-1:1]};
							if (bit_index == BIT_WIDTH'(`UART_DATA_BITS - 1)) begin
								state <= rx_stop;
							end else begin
								bit_index <= bit_index + 1'b1;
							end
						end
						default: begin
							// Frame is kept only with a high stop bit.
							o_valid <= rx_sync[1];
							o_interrupt <= rx_sync[1];
							state <= rx_idle;
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_transmitter.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uart_transmitter (
	input  wire logic                       i_clock,
	input  wire logic                       i_reset,
	input  wire logic                       i_fifo_empty,
	input  wire logic [`UART_DATA_BITS-1:0] i_fifo_data,
	output logic                            o_fifo_read,
	output logic                            o_uart_tx
);
	localparam int FRAME_BITS = `UART_DATA_BITS + 2;
	localparam int PERIOD_WIDTH = $clog2(`UART_CLOCKS_PER_BIT);
	localparam int BIT_WIDTH = $clog2(FRAME_BITS);

	logic [FRAME_BITS-1:0] shift;
	logic [PERIOD_WIDTH-1:0] period_count;
	logic [BIT_WIDTH-1:0] bit_count;
	logic busy;
	logic load_pending;

	// Line is the low end of the shift register.
	assign o_uart_tx = shift[0];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			shift <= '1;
			period_count <= '0;
			bit_count <= '0;
			busy <= 1'b0;
			load_pending <= 1'b0;
			o_fifo_read <= 1'b0;
		end else begin
			o_fifo_read <= 1'b0;
			if (o_fifo_read) begin
				// Start bit goes out while the FIFO fetches the byte.
				shift <= {{(FRAME_BITS - 1){1'b1}}, 1'b0};
				period_count <= PERIOD_WIDTH'(`UART_CLOCKS_PER_BIT - 1);
				bit_count <= '0;
				busy <= 1'b1;
				load_pending <= 1'b1;
			end else if (busy) begin
				if (load_pending) begin
					shift[FRAME_BITS-1:1] <= {1'b1, i_fifo_data};
					load_pending <= 1'b0;
				end
				if (period_count == '0) begin
					shift <= {1'b1, shift[FRAME_BITS-1:1]};
					period_count <= PERIOD_WIDTH'(`UART_CLOCKS_PER_BIT - 1);
					if (bit_count == BIT_WIDTH'(FRAME_BITS - 1)) begin
						busy <= 1'b0;
					end else begin
						bit_count <= bit_count + 1'b1;
					end
				end else begin
					period_count <= period_count - 1'b1;
				end
			end else if (!i_fifo_empty) begin
				o_fifo_read <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_registers.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uart_registers (
	input  wire logic                       i_clock,
	input  wire logic                       i_reset,
	input  wire logic                       i_request,
	input  wire logic                       i_write,
	input  wire uart_pkg::reg_address_t     i_address,
	input  wire logic [`UART_DATA_BITS-1:0] i_wdata,
	input  wire logic                       i_rx_empty,
	input  wire logic                       i_rx_full,
	input  wire logic                       i_rx_write,
	input  wire logic [`UART_DATA_BITS-1:0] i_rx_data,
	input  wire logic                       i_tx_full,
	output logic      [31:0]                o_rdata,
	output logic                            o_ready,
	output logic                            o_rx_read,
	output logic                            o_tx_write,
	output logic      [`UART_DATA_BITS-1:0] o_tx_data
);
	import uart_pkg::*;

	typedef enum logic [1:0] {
		seq_idle,
		seq_pulse,
		seq_latch,
		seq_done
	} seq_state_t;

	seq_state_t seq;
	logic overflow;

	assign o_ready = (seq == seq_done) && i_request;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			seq <= seq_idle;
			overflow <= 1'b0;
			o_rdata <= '0;
			o_rx_read <= 1'b0;
			o_tx_write <= 1'b0;
		end else begin
			o_rx_read <= 1'b0;
			o_tx_write <= 1'b0;
			if (!i_request) begin
				seq <= seq_idle;
			end else begin
				case (seq)
					seq_idle: begin
						if (i_write) begin
							// A full TX FIFO loses the byte but still acks.
							o_tx_write <= (i_address == reg_tx_data) && !i_tx_full;
							o_tx_data <= i_wdata;
							seq <= seq_done;
						end else if (i_address == reg_status) begin
							o_rdata <= {29'b0, overflow, i_tx_full, i_rx_empty};
							overflow <= 1'b0;
							seq <= seq_done;
						end else if (i_address == reg_rx_data) begin
							// Stalls here until a byte arrives.
							if (!i_rx_empty) begin
								o_rx_read <= 1'b1;
								seq <= seq_pulse;
							end
						end else begin
							o_rdata <= '0;
							seq <= seq_done;
						end
					end
					seq_pulse: seq <= seq_latch;
					seq_latch: begin
						o_rdata <= {{(32 - `UART_DATA_BITS){1'b0}}, i_rx_data};
						seq <= seq_done;
					end
					default: seq <= seq_done;
				endcase
			end
			// Sticky overflow, set after any clear in the same cycle.
			if (i_rx_write && i_rx_full) begin
				overflow <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uart (
	input  wire logic                       i_clock,
	input  wire logic                       i_reset,
	input  wire logic                       i_request,
	input  wire logic                       i_write,
	input  wire uart_pkg::reg_address_t     i_address,
	input  wire logic [`UART_DATA_BITS-1:0] i_wdata,
	input  wire logic                       i_uart_rx,
	output logic      [31:0]                o_rdata,
	output logic                            o_ready,
	output logic                            o_interrupt,
	output logic                            o_uart_tx
);
	logic rx_write;
	logic [`UART_DATA_BITS-1:0] rx_byte;
	logic rx_read;
	logic [`UART_DATA_BITS-1:0] rx_fifo_data;
	logic rx_empty;
	logic rx_full;
	logic tx_write;
	logic [`UART_DATA_BITS-1:0] tx_byte;
	logic tx_read;
	logic [`UART_DATA_BITS-1:0] tx_fifo_data;
	logic tx_empty;
	logic tx_full;

	uart_receiver u_receiver (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_uart_rx   (i_uart_rx),
		.o_valid     (rx_write),
		.o_data      (rx_byte),
		.o_interrupt (o_interrupt)
	);

	uart_fifo #(
		.WIDTH (`UART_DATA_BITS),
		.DEPTH (`UART_FIFO_DEPTH)
	) u_rx_fifo (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_write (rx_write),
		.i_wdata (rx_byte),
		.i_read  (rx_read),
		.o_rdata (rx_fifo_data),
		.o_empty (rx_empty),
		.o_full  (rx_full)
	);

	uart_registers u_registers (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_request  (i_request),
		.i_write    (i_write),
		.i_address  (i_address),
		.i_wdata    (i_wdata),
		.i_rx_empty (rx_empty),
		.i_rx_full  (rx_full),
		.i_rx_write (rx_write),
		.i_rx_data  (rx_fifo_data),
		.i_tx_full  (tx_full),
		.o_rdata    (o_rdata),
		.o_ready    (o_ready),
		.o_rx_read  (rx_read),
		.o_tx_write (tx_write),
		.o_tx_data  (tx_byte)
	);

	uart_fifo #(
		.WIDTH (`UART_DATA_BITS),
		.DEPTH (`UART_FIFO_DEPTH)
	) u_tx_fifo (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_write (tx_write),
		.i_wdata (tx_byte),
		.i_read  (tx_read),
		.o_rdata (tx_fifo_data),
		.o_empty (tx_empty),
		.o_full  (tx_full)
	);

	uart_transmitter u_transmitter (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_fifo_empty (tx_empty),
		.i_fifo_data  (tx_fifo_data),
		.o_fifo_read  (tx_read),
		.o_uart_tx    (o_uart_tx)
	);

endmodule

`default_nettype wire

//--- test/uart_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uart_checker (
	input  wire logic                i_clock,
	input  wire logic                i_reset,
	input  wire logic                i_request,
	input  wire logic                i_write,
	input  wire uart_pkg::reg_address_t i_address,
	input  wire logic [31:0]         i_rdata,
	input  wire logic                i_ready,
	input  wire logic                i_interrupt,
	input  wire logic                i_uart_tx
);
	import uart_pkg::*;

	localparam int CLOCKS = `UART_CLOCKS_PER_BIT;
	localparam int FRAME_BITS = `UART_DATA_BITS + 2;

	logic [`UART_DATA_BITS-1:0] rx_expected [$];
	logic [`UART_DATA_BITS-1:0] tx_expected [$];
	logic [31:0] status_mask [$];
	logic [31:0] status_value [$];
	int interrupts_pending = 0;
	int latency = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic tx_previous;

	task automatic rx_byte_expected(input logic [`UART_DATA_BITS-1:0] data);
		rx_expected.push_back(data);
	endtask

	task automatic tx_byte_expected(input logic [`UART_DATA_BITS-1:0] data);
		tx_expected.push_back(data);
	endtask

	// Only the bits under the mask are compared.
	task automatic status_expected(input logic [31:0] mask, input logic [31:0] value);
		status_mask.push_back(mask);
		status_value.push_back(value);
	endtask

	task automatic interrupt_expected();
		interrupts_pending++;
	endtask

	function automatic int frames_in_flight();
		return tx_expected.size();
	endfunction

	task automatic final_checks();
		if (rx_expected.size() != 0) begin
			$display("%0d received bytes were never read back", rx_expected.size());
			other_errors++;
		end
		if (interrupts_pending != 0) begin
			$display("%0d interrupt pulses never came", interrupts_pending);
			other_errors++;
		end
		if (status_mask.size() != 0) begin
			$display("%0d status reads were never done", status_mask.size());
			other_errors++;
		end
	endtask

	// Data reads take three edges, everything else one.
	task automatic check_bus_response();
		int expected_latency;
		logic [31:0] expected;
		logic [31:0] mask;
		expected_latency = (!i_write && i_address == reg_rx_data) ? 3 : 1;
		if (latency != expected_latency) begin
			$display("CHECK FAILED o_ready latency: expected %0h, got %0h",
				expected_latency, latency);
			value_errors++;
		end
		if (!i_write && i_address == reg_rx_data) begin
			if (rx_expected.size() == 0) begin
				$display("Data read returned a byte that no frame carried");
				other_errors++;
			end else begin
				expected = {24'b0, rx_expected.pop_front()};
				if (i_rdata !== expected) begin
					$display("CHECK FAILED o_rdata: expected %h, got %h", expected, i_rdata);
					value_errors++;
				end
			end
		end else if (!i_write && i_address == reg_status && status_mask.size() != 0) begin
			mask = status_mask.pop_front();
			expected = status_value.pop_front();
			if ((i_rdata & mask) !== expected) begin
				$display("CHECK FAILED o_rdata status: expected %h under mask %h, got %h",
					expected, mask, i_rdata);
				value_errors++;
			end
		end
	endtask

	always @(posedge i_clock) begin
		if (i_reset || !i_request) begin
			latency = 0;
		end else if (!i_ready) begin
			latency++;
		end else begin
			check_bus_response();
		end
	end

	always @(posedge i_clock) begin
		if (!i_reset && i_interrupt === 1'b1) begin
			if (interrupts_pending == 0) begin
				$display("Interrupt pulse without a good frame on the receive line");
				other_errors++;
			end else begin
				interrupts_pending--;
			end
		end
	end

	// Called on the first low sample, so that edge is cycle 0 of the start bit.
	task automatic decode_tx_frame();
		logic [CLOCKS-1:0] samples;
		logic [FRAME_BITS-1:0] frame;
		logic [`UART_DATA_BITS-1:0] expected;
		logic uneven;
		int b;
		int c;
		uneven = 1'b0;
		for (b = 0; b < FRAME_BITS; b++) begin
			for (c = 0; c < CLOCKS; c++) begin
				if (b != 0 || c != 0) begin
					@(posedge i_clock);
				end
				samples[c] = i_uart_tx;
			end
			frame[b] = samples[CLOCKS/2];
			if (samples !== {CLOCKS{frame[b]}}) begin
				uneven = 1'b1;
			end
		end
		if (uneven) begin
			$display("Serial output changed within a bit period of a transmitted frame");
			other_errors++;
		end
		if (frame[0] !== 1'b0) begin
			$display("CHECK FAILED o_uart_tx start bit: expected 0, got %h", frame[0]);
			value_errors++;
		end
		if (frame[FRAME_BITS-1] !== 1'b1) begin
			$display("CHECK FAILED o_uart_tx stop bit: expected 1, got %h",
				frame[FRAME_BITS-1]);
			value_errors++;
		end
		if (tx_expected.size() == 0) begin
			$display("Frame on the serial output with no byte written for it");
			other_errors++;
		end else begin
			expected = tx_expected.pop_front();
			if (frame[FRAME_BITS-2:1] !== expected) begin
				$display("CHECK FAILED o_uart_tx data: expected %h, got %h",
					expected, frame[FRAME_BITS-2:1]);
				value_errors++;
			end
		end
	endtask

	initial begin
		tx_previous = 1'b1;
		forever begin
			@(posedge i_clock);
			if (!i_reset && tx_previous === 1'b1 && i_uart_tx === 1'b0) begin
				decode_tx_frame();
				tx_previous = 1'b1;
			end else begin
				tx_previous = i_uart_tx;
			end
		end
	end

endmodule

`default_nettype wire

//--- test/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uart_tb;
	import uart_pkg::*;

	localparam int CLOCKS = `UART_CLOCKS_PER_BIT;
	localparam int FRAME_BITS = `UART_DATA_BITS + 2;
	localparam int BUS_TIMEOUT = 32;
	localparam int TX_TIMEOUT = (`UART_FIFO_DEPTH + 1) * FRAME_BITS * CLOCKS;

	logic clock;
	logic reset;
	logic request;
	logic write;
	reg_address_t address;
	logic [`UART_DATA_BITS-1:0] wdata;
	logic uart_rx;
	logic [31:0] rdata;
	logic ready;
	logic interrupt;
	logic uart_tx;

	logic [31:0] lfsr_state;
	int pending_bytes;
	int timeouts;
	int file_errors;
	int fd;
	int ch;
	logic [7:0] letter;
	logic [`UART_DATA_BITS-1:0] value;

	uart u_dut (
		.i_clock     (clock),
		.i_reset     (reset),
		.i_request   (request),
		.i_write     (write),
		.i_address   (address),
		.i_wdata     (wdata),
		.i_uart_rx   (uart_rx),
		.o_rdata     (rdata),
		.o_ready     (ready),
		.o_interrupt (interrupt),
		.o_uart_tx   (uart_tx)
	);

	uart_checker u_check (
		.i_clock     (clock),
		.i_reset     (reset),
		.i_request   (request),
		.i_write     (write),
		.i_address   (address),
		.i_rdata     (rdata),
		.i_ready     (ready),
		.i_interrupt (interrupt),
		.i_uart_tx   (uart_tx)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Idle line for 0 to 7 bit periods.
	task automatic idle_gap();
		logic [2:0] gap;
		int b;
		gap = 3'd0;
		for (b = 0; b < 3; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			gap = {gap[1:0], lfsr_state[0]};
		end
		uart_rx = 1'b1;
		repeat (int'(gap) * CLOCKS) @(negedge clock);
	endtask

	task automatic send_frame(input logic [`UART_DATA_BITS-1:0] data, input logic stop_bit);
		logic [FRAME_BITS-1:0] frame;
		int b;
		frame = {stop_bit, data, 1'b0};
		for (b = 0; b < FRAME_BITS; b++) begin
			uart_rx = frame[b];
			repeat (CLOCKS) @(negedge clock);
		end
		uart_rx = 1'b1;
		// A low stop bit looks like a new start, so let the receiver settle.
		if (!stop_bit) begin
			repeat (2 * CLOCKS) @(negedge clock);
		end
		idle_gap();
	endtask

	task automatic send_glitch(input logic [`UART_DATA_BITS-1:0] length);
		uart_rx = 1'b0;
		repeat (int'(length)) @(negedge clock);
		uart_rx = 1'b1;
		repeat (2 * CLOCKS) @(negedge clock);
	endtask

	// Holds the request until ready, then drops it for a cycle.
	task automatic bus_access(input logic is_write, input reg_address_t where,
		input logic [`UART_DATA_BITS-1:0] data);
		int cycles;
		logic seen;
		request = 1'b1;
		write = is_write;
		address = where;
		wdata = data;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < BUS_TIMEOUT) begin
			@(posedge clock);
			seen = ready;
			cycles++;
		end
		if (!seen) begin
			$display("Timeout: bus access to address %0d never got ready", where);
			timeouts++;
		end
		@(negedge clock);
		request = 1'b0;
		write = 1'b0;
		@(negedge clock);
	endtask

	task automatic status_read(input logic [31:0] mask, input logic [31:0] expected);
		u_check.status_expected(mask, expected);
		bus_access(1'b0, reg_status, '0);
	endtask

	// The RX FIFO keeps the first DEPTH bytes and drops the rest.
	task automatic overflow_burst(input logic [`UART_DATA_BITS-1:0] first);
		logic [`UART_DATA_BITS-1:0] data;
		int i;
		data = first;
		for (i = 0; i <= `UART_FIFO_DEPTH; i++) begin
			u_check.interrupt_expected();
			if (pending_bytes < `UART_FIFO_DEPTH) begin
				u_check.rx_byte_expected(data);
				pending_bytes++;
			end
			send_frame(data, 1'b1);
			data = data + 1'b1;
		end
		status_read(32'h4, 32'h4);
		status_read(32'h4, 32'h0);
	endtask

	task automatic drain_rx_fifo();
		status_read(32'h1, (pending_bytes == 0) ? 32'h1 : 32'h0);
		while (pending_bytes > 0) begin
			bus_access(1'b0, reg_rx_data, '0);
			pending_bytes--;
		end
		status_read(32'h1, 32'h1);
	endtask

	task automatic run_command(input logic [7:0] command, input logic [`UART_DATA_BITS-1:0] data);
		case (command)
			"R": begin
				u_check.rx_byte_expected(data);
				u_check.interrupt_expected();
				pending_bytes++;
				send_frame(data, 1'b1);
			end
			"B": begin
				send_frame(data, 1'b0);
				status_read(32'h1, (pending_bytes == 0) ? 32'h1 : 32'h0);
			end
			"G": begin
				send_glitch(data);
				status_read(32'h1, (pending_bytes == 0) ? 32'h1 : 32'h0);
			end
			"T": begin
				u_check.tx_byte_expected(data);
				bus_access(1'b1, reg_tx_data, data);
			end
			"O": overflow_burst(data);
			"D": drain_rx_fifo();
			default: begin
				$display("Unknown command %c in the test data", command);
				file_errors++;
			end
		endcase
	endtask

	task automatic wait_tx_done();
		int cycles;
		cycles = 0;
		while (u_check.frames_in_flight() != 0 && cycles < TX_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (u_check.frames_in_flight() != 0) begin
			$display("Timeout: %0d written bytes never left the serial output",
				u_check.frames_in_flight());
			timeouts++;
		end
	endtask

	initial begin
		reset = 1'b1;
		request = 1'b0;
		write = 1'b0;
		address = reg_rx_data;
		wdata = '0;
		uart_rx = 1'b1;
		lfsr_state = 32'h98134ff9;
		pending_bytes = 0;
		timeouts = 0;
		file_errors = 0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		fd = $fopen("test/uart_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/uart_testdata.txt");
			file_errors++;
		end else begin
			while ($fscanf(fd, " %c", letter) == 1) begin
				if (letter == "#") begin
					ch = 0;
					while (ch != 10 && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else if ($fscanf(fd, "%h", value) == 1) begin
					run_command(letter, value);
				end else begin
					$display("Command %c in the test data has no byte", letter);
					file_errors++;
				end
			end
			$fclose(fd);
		end
		wait_tx_done();
		u_check.final_checks();
		$display("Errors: %0d wrong values, %0d other, %0d timeouts, %0d test data",
			u_check.value_errors, u_check.other_errors, timeouts, file_errors);
		if (u_check.value_errors + u_check.other_errors + timeouts + file_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_receiver.sv
rtl/uart_transmitter.sv
rtl/uart_registers.sv
rtl/uart.sv
test/uart_checker.sv
test/uart_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build uart_tb with Verilator, run it and search $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module uart_tb -f all.f -o uart_sim
	./obj_dir/uart_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/uart_testdata.txt
# Columns: command letter, hex byte.
# R good frame, B low stop bit, G low glitch of n clocks, T transmit, O overflow burst, D drain.
R 41
R 5a
R 00
R ff
D 00
B 3c
G 05
R a5
B 81
R 7e
D 00
T 55
T 0f
T c3
O 30
D 00
T 81
G 03
R 96
D 00
